// ==== design/arm_exec_pkg.sv ====
`default_nettype none

package arm_exec_pkg;

	// Execute class chosen by the instruction classifier.
	typedef enum logic [3:0] {
		CLS_NOP    = 4'd0,
		CLS_MUL    = 4'd1,
		CLS_MRS    = 4'd2,
		CLS_MSR    = 4'd3,
		CLS_ALU    = 4'd4,
		CLS_BRANCH = 4'd5
	} exec_class_e;

	// Data-processing opcodes, insn[24:21], architectural order.
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'ha,
		ALU_CMN = 4'hb,
		ALU_ORR = 4'hc,
		ALU_MOV = 4'hd,
		ALU_BIC = 4'he,
		ALU_MVN = 4'hf
	} alu_op_e;

	// Flag positions in a status word.
	parameter int cpsr_n = 31;
	parameter int cpsr_z = 30;
	parameter int cpsr_c = 29;
	parameter int cpsr_v = 28;

	// User mode in the low five bits.
	parameter logic [4:0] mode_usr = 5'b10000;

	// Link register for BL.
	parameter logic [3:0] reg_link = 4'd14;

	// Multiplier bits retired per cycle.
	parameter int mult_bits_default = 2;

endpackage

`default_nettype wire

// ==== design/insn_classifier.sv ====
`timescale 1ns/100ps
`default_nettype none

module insn_classifier (
	input  logic [31:0]              insn,
	output arm_exec_pkg::exec_class_e insn_class
);
	import arm_exec_pkg::*;

	logic is_mul;
	logic is_mul_long;
	logic is_swap;
	logic is_mrs;
	logic is_bx;
	logic is_msr;
	logic is_half;
	logic is_dp;
	logic is_branch;

	// MUL/MLA sits inside the data-processing space.
	assign is_mul      = (insn[27:22] == 6'b000000) && (insn[7:4] == 4'b1001);
	assign is_mul_long = (insn[27:23] == 5'b00001) && (insn[7:4] == 4'b1001);
	assign is_swap     = (insn[27:23] == 5'b00010) && (insn[21:20] == 2'b00) &&
	                     (insn[11:4] == 8'b0000_1001);
	assign is_mrs      = (insn[27:23] == 5'b00010) && (insn[21:16] == 6'b001111) &&
	                     (insn[11:0] == 12'h000);
	assign is_bx       = (insn[27:4] == 24'h12fff1);

	// Register and immediate forms, whole word or flags only.
	assign is_msr      = (insn[27:26] == 2'b00) && (insn[24:23] == 2'b10) &&
	                     (insn[21:20] == 2'b10) && (insn[15:12] == 4'b1111);
	assign is_half     = (insn[27:25] == 3'b000) && insn[7] && insn[4] &&
	                     (insn[6:5] != 2'b00);
	assign is_dp       = (insn[27:26] == 2'b00);
	assign is_branch   = (insn[27:25] == 3'b101);

	// Priority order matters here.
	always_comb begin
		if (is_mul)
			insn_class = CLS_MUL;
		else if (is_mul_long || is_swap)
			insn_class = CLS_NOP;
		else if (is_mrs)
			insn_class = CLS_MRS;
		else if (is_bx)
			insn_class = CLS_NOP;
		else if (is_msr)
			insn_class = CLS_MSR;
		else if (is_half)
			insn_class = CLS_NOP;
		else if (is_dp)
			insn_class = CLS_ALU;
		else if (is_branch)
			insn_class = CLS_BRANCH;
		else
			// Load/store, block transfer, coprocessor and SWI.
			insn_class = CLS_NOP;
	end

endmodule

`default_nettype wire

// ==== design/exec_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
	input  logic [31:0]          in0,
	input  logic [31:0]          in1,
	input  logic [31:0]          cpsr,
	input  arm_exec_pkg::alu_op_e op,
	input  logic                 set_flags,
	input  logic                 shifter_carry,
	output logic [31:0]          result,
	output logic [31:0]          cpsr_out,
	output logic                 writes_result
);
	import arm_exec_pkg::*;

	logic [31:0] add_a;
	logic [31:0] add_b;
	logic        add_cin;
	logic [32:0] add_full;
	logic        add_v;
	logic        arith;
	logic        flag_c;
	logic        flag_v;

	// Operand select for the shared 33-bit adder.
	// Subtraction is a + ~b + 1, so bit 32 is the ARM carry.
	always_comb begin
		add_a   = in0;
		add_b   = in1;
		add_cin = 1'b0;
		case (op)
			ALU_SUB, ALU_CMP: begin
				add_b   = ~in1;
				add_cin = 1'b1;
			end
			ALU_RSB: begin
				add_a   = in1;
				add_b   = ~in0;
				add_cin = 1'b1;
			end
			ALU_ADC: begin
				add_cin = cpsr[cpsr_c];
			end
			ALU_SBC: begin
				add_b   = ~in1;
				add_cin = cpsr[cpsr_c];
			end
			ALU_RSC: begin
				add_a   = in1;
				add_b   = ~in0;
				add_cin = cpsr[cpsr_c];
			end
			default: begin
				add_cin = 1'b0;
			end
		endcase
	end

	assign add_full = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};

	// Overflow when both addends agree in sign and the sum does not.
	assign add_v = (add_a[31] == add_b[31]) && (add_full[31] != add_a[31]);

	always_comb begin
		result = add_full[31:0];
		arith  = 1'b0;
		case (op)
			ALU_AND, ALU_TST: result = in0 & in1;
			ALU_EOR, ALU_TEQ: result = in0 ^ in1;
			ALU_ORR:          result = in0 | in1;
			ALU_MOV:          result = in1;
			ALU_BIC:          result = in0 & ~in1;
			ALU_MVN:          result = ~in1;
			default:          arith  = 1'b1;
		endcase
	end

	// Compares and tests only touch the flags.
	assign writes_result = !(op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});

	assign flag_c = arith ? add_full[32] : shifter_carry;
	assign flag_v = arith ? add_v : cpsr[cpsr_v];

	always_comb begin
		cpsr_out = cpsr;
		if (set_flags) begin
			cpsr_out[cpsr_n] = result[31];
			cpsr_out[cpsr_z] = (result == 32'd0);
			cpsr_out[cpsr_c] = flag_c;
			cpsr_out[cpsr_v] = flag_v;
		end
	end

endmodule

`default_nettype wire

// ==== design/exec_multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_multiplier #(
	parameter int mult_bits = arm_exec_pkg::mult_bits_default
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic [31:0] acc,
	input  logic [31:0] in0,
	input  logic [31:0] in1,
	output logic        done,
	output logic [31:0] result
);

	logic        busy;
	logic [31:0] bitfield;
	logic [31:0] multiplicand;
	logic [31:0] acc_q;
	logic [31:0] partial;

	// Sum of the partial products for this step.
	always_comb begin
		partial = 32'd0;
		for (int i = 0; i < mult_bits; i++) begin
			if (bitfield[i])
				partial = partial + (multiplicand << i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy && (bitfield == 32'd0)) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	// Datapath runs without reset.
	always_ff @(posedge clk) begin
		if (start) begin
			bitfield     <= in0;
			multiplicand <= in1;
			acc_q        <= acc;
		end else if (busy) begin
			bitfield     <= bitfield >> mult_bits;
			multiplicand <= multiplicand << mult_bits;
			acc_q        <= acc_q + partial;
			if (bitfield == 32'd0)
				result <= acc_q;
		end
	end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
	parameter int mult_bits = arm_exec_pkg::mult_bits_default
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  logic        in_bubble,
	input  logic [31:0] pc,
	input  logic [31:0] insn,
	input  logic [31:0] cpsr,
	input  logic [31:0] spsr,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic        carry,
	output logic        out_stall,
	output logic        out_bubble,
	output logic [31:0] out_cpsr,
	output logic [31:0] out_spsr,
	output logic        out_cpsr_up,
	output logic        write_reg,
	output logic [3:0]  write_num,
	output logic [31:0] write_data,
	output logic [31:0] out_pc,
	output logic [31:0] out_insn,
	output logic [31:0] out_op0,
	output logic [31:0] out_op1,
	output logic [31:0] out_op2,
	output logic        jmp,
	output logic [31:0] jmp_pc
);
	import arm_exec_pkg::*;

	exec_class_e insn_class;

	logic        mult_start;
	logic [31:0] mult_acc;
	logic        mult_done;
	logic [31:0] mult_result;

	logic [31:0] alu_result;
	logic [31:0] alu_cpsr;
	logic        alu_writes;

	logic        prev_stall;
	logic        delayed_flush;
	logic        flags_only;

	logic        next_bubble;
	logic [31:0] next_cpsr;
	logic [31:0] next_spsr;
	logic        next_cpsr_up;
	logic        next_write_reg;
	logic [3:0]  next_write_num;
	logic [31:0] next_write_data;

	insn_classifier u_classifier (
		.insn       (insn),
		.insn_class (insn_class)
	);

	exec_alu u_alu (
		.in0           (op0),
		.in1           (op1),
		.cpsr          (cpsr),
		.op            (alu_op_e'(insn[24:21])),
		.set_flags     (insn[20]),
		.shifter_carry (carry),
		.result        (alu_result),
		.cpsr_out      (alu_cpsr),
		.writes_result (alu_writes)
	);

	// Accumulate only for MLA.
	assign mult_acc = insn[21] ? op0 : 32'd0;

	exec_multiplier #(.mult_bits(mult_bits)) u_mult (
		.clk    (clk),
		.rst    (rst),
		.start  (mult_start),
		.acc    (mult_acc),
		.in0    (op1),
		.in1    (op2),
		.done   (mult_done),
		.result (mult_result)
	);

	// MSR touches only NZCV in user mode or with bit 16 clear.
	assign flags_only = (cpsr[4:0] == mode_usr) || !insn[16];

	always_comb begin
		out_stall       = stall;
		next_bubble     = in_bubble | flush | delayed_flush;
		next_cpsr       = cpsr;
		next_spsr       = spsr;
		next_cpsr_up    = 1'b0;
		next_write_reg  = 1'b0;
		next_write_num  = insn[15:12];
		next_write_data = alu_result;
		mult_start      = 1'b0;
		jmp             = 1'b0;
		jmp_pc          = 32'd0;
		case (insn_class)
			CLS_MUL: begin
				// First cycle of a fresh multiply.
				mult_start  = !prev_stall && !in_bubble;
				out_stall   = stall | ((!prev_stall | !mult_done) & !in_bubble);
				next_bubble = next_bubble | !mult_done | !prev_stall;
				if (insn[20]) begin
					next_cpsr[cpsr_n] = mult_result[31];
					next_cpsr[cpsr_z] = (mult_result == 32'd0);
					next_cpsr[cpsr_c] = 1'b0;
				end
				next_cpsr_up    = insn[20];
				next_write_reg  = 1'b1;
				next_write_num  = insn[19:16];
				next_write_data = mult_result;
			end
			CLS_MRS: begin
				next_write_reg  = 1'b1;
				next_write_data = insn[22] ? spsr : cpsr;
			end
			CLS_MSR: begin
				if (insn[22])
					next_spsr = flags_only ? {op0[cpsr_n:cpsr_v], spsr[cpsr_v-1:0]} : op0;
				else
					next_cpsr = flags_only ? {op0[cpsr_n:cpsr_v], cpsr[cpsr_v-1:0]} : op0;
				next_cpsr_up = 1'b1;
			end
			CLS_ALU: begin
				next_write_reg = alu_writes;
				// S with Rd of r15 is the exception return.
				next_cpsr    = ((insn[15:12] == 4'hf) && insn[20]) ? spsr : alu_cpsr;
				next_cpsr_up = insn[20];
			end
			CLS_BRANCH: begin
				if (!in_bubble && !flush && !delayed_flush && !out_stall) begin
					jmp             = 1'b1;
					jmp_pc          = pc + op0 + 32'd8;
					next_write_reg  = insn[24];
					next_write_num  = reg_link;
					next_write_data = pc + 32'd4;
				end
			end
			default: begin
				next_write_reg = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_bubble  <= 1'b1;
			out_cpsr_up <= 1'b0;
			write_reg   <= 1'b0;
		end else if (!stall) begin
			out_bubble  <= next_bubble;
			// A bubble carries no write and no flag update.
			out_cpsr_up <= next_cpsr_up && !next_bubble;
			write_reg   <= next_write_reg && !next_bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out_cpsr   <= next_cpsr;
			out_spsr   <= next_spsr;
			write_num  <= next_write_num;
			write_data <= next_write_data;
			out_pc     <= pc;
			out_insn   <= insn;
			out_op0    <= op0;
			out_op1    <= op1;
			out_op2    <= op2;
		end
	end

	// A flush seen while stalled is held until the stage moves.
	always_ff @(posedge clk) begin
		if (rst) begin
			prev_stall    <= 1'b0;
			delayed_flush <= 1'b0;
		end else begin
			prev_stall <= out_stall;
			if (flush && out_stall)
				delayed_flush <= 1'b1;
			else if (!out_stall)
				delayed_flush <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/exec_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit_top #(
	parameter int mult_bits = arm_exec_pkg::mult_bits_default
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  logic        in_bubble,
	input  logic [31:0] pc,
	input  logic [31:0] insn,
	input  logic [31:0] cpsr,
	input  logic [31:0] spsr,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic        carry,
	output logic        out_stall,
	output logic        out_bubble,
	output logic [31:0] out_cpsr,
	output logic [31:0] out_spsr,
	output logic        out_cpsr_up,
	output logic        write_reg,
	output logic [3:0]  write_num,
	output logic [31:0] write_data,
	output logic [31:0] out_pc,
	output logic [31:0] out_insn,
	output logic [31:0] out_op0,
	output logic [31:0] out_op1,
	output logic [31:0] out_op2,
	output logic        jmp,
	output logic [31:0] jmp_pc
);

	execute_stage #(.mult_bits(mult_bits)) u_exec (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.flush       (flush),
		.in_bubble   (in_bubble),
		.pc          (pc),
		.insn        (insn),
		.cpsr        (cpsr),
		.spsr        (spsr),
		.op0         (op0),
		.op1         (op1),
		.op2         (op2),
		.carry       (carry),
		.out_stall   (out_stall),
		.out_bubble  (out_bubble),
		.out_cpsr    (out_cpsr),
		.out_spsr    (out_spsr),
		.out_cpsr_up (out_cpsr_up),
		.write_reg   (write_reg),
		.write_num   (write_num),
		.write_data  (write_data),
		.out_pc      (out_pc),
		.out_insn    (out_insn),
		.out_op0     (out_op0),
		.out_op1     (out_op1),
		.out_op2     (out_op2),
		.jmp         (jmp),
		.jmp_pc      (jmp_pc)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_exec_model.svh ====
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1.
logic [31:0] lfsr_state = 32'd50;

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] w;
	logic        fb;
	w = 32'd0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		w = {w[30:0], fb};
	end
	return w;
endfunction

// Reference data-processing result and flags.
task automatic alu_model(input logic [3:0] op, input logic [31:0] a, b, psr, spsr_in,
		input logic s, sc, input logic [3:0] rd,
		output logic [31:0] res, output logic [31:0] psr_new, output logic wr);
	logic [32:0] full;
	logic [31:0] x;
	logic [31:0] y;
	logic        sub;
	logic        ci;
	logic        c;
	logic        v;
	c = sc;
	v = psr[28];
	case (op)
		4'h0, 4'h8: res = a & b;
		4'h1, 4'h9: res = a ^ b;
		4'hc: res = a | b;
		4'hd: res = b;
		4'he: res = a & ~b;
		4'hf: res = ~b;
		default: begin
			sub = op inside {4'h2, 4'h3, 4'h6, 4'h7, 4'ha};
			x = (op == 4'h3 || op == 4'h7) ? b : a;
			y = (op == 4'h3 || op == 4'h7) ? a : b;
			ci = (op == 4'h6 || op == 4'h7) ? !psr[29] : (op == 4'h5) ? psr[29] : 1'b0;
			// Bit 32 is a borrow for subtraction, a carry for addition.
			full = sub ? ({1'b0, x} - {1'b0, y} - ci) : ({1'b0, x} + {1'b0, y} + ci);
			res = full[31:0];
			c = sub ? !full[32] : full[32];
			v = sub ? (x[31] != y[31]) && (res[31] != x[31])
			        : (x[31] == y[31]) && (res[31] != x[31]);
		end
	endcase
	psr_new = psr;
	if (s && rd == 4'hf)
		psr_new = spsr_in;
	else if (s)
		psr_new[31:28] = {res[31], res == 32'd0, c, v};
	wr = !(op inside {4'h8, 4'h9, 4'ha, 4'hb});
endtask

function automatic logic [31:0] msr_model(input logic [31:0] old, val, input logic fo);
	return fo ? {val[31:28], old[27:0]} : val;
endfunction

`endif

// ==== testbench/tb_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_unit;
	localparam int n_alu = 200;
	localparam int n_mul = 60;
	localparam int n_psr = 40;
	localparam int n_br = 40;
	localparam int mul_max = 32 / arm_exec_pkg::mult_bits_default + 2;
	localparam int n_vec = n_alu + n_mul + 2 * n_psr + 3 * n_br + 3 * 4;
	localparam int timeout_ns = (n_vec + 20) * (mul_max + 3) * 8 + 2000;

	logic        clk, rst, stall, flush, in_bubble, carry;
	logic [31:0] pc, insn, cpsr, spsr, op0, op1, op2;
	logic        out_stall, out_bubble, out_cpsr_up, write_reg, jmp;
	logic [3:0]  write_num;
	logic [31:0] out_cpsr, out_spsr, write_data, out_pc, out_insn;
	logic [31:0] out_op0, out_op1, out_op2, jmp_pc;
	logic [31:0] sent_pc, sent_insn, sent_op0, sent_op1, sent_op2;
	int          errors = 0;
	int          checks = 0;
	int          total_checks = 0;
	int          test_errs = 0;

	`include "tb_exec_model.svh"

	exec_unit_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within the expected time");
		$display("Simulation FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] exp, act);
		checks++;
		total_checks++;
		assert (exp === act) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks, test_errs);
		checks = 0;
		test_errs = 0;
	endtask

	task automatic drive(input logic ib, fl, input logic [31:0] i, p, c, s, a0, a1, a2,
			input logic cr);
		@(posedge clk);
		in_bubble <= ib;
		flush <= fl;
		insn <= i;
		pc <= p;
		cpsr <= c;
		spsr <= s;
		op0 <= a0;
		op1 <= a1;
		op2 <= a2;
		carry <= cr;
		sent_pc = p;
		sent_insn = i;
		sent_op0 = a0;
		sent_op1 = a1;
		sent_op2 = a2;
	endtask

	// Wait for acceptance, then leave the outputs of the taken word visible.
	task automatic wait_accept(output logic j0, output logic [31:0] jp0);
		int cyc;
		cyc = 0;
		@(negedge clk);
		j0 = jmp;
		jp0 = jmp_pc;
		while (out_stall && cyc <= mul_max) begin
			check("out_bubble", 1'b1, out_bubble);
			check("write_reg", 1'b0, write_reg);
			cyc++;
			@(negedge clk);
		end
		assert (!out_stall) else begin
			$display("out_stall stayed high too long at %0t", $time);
			errors++;
			test_errs++;
		end
		@(posedge clk);
		in_bubble <= 1'b1;
		flush <= 1'b0;
		@(negedge clk);
	endtask

	task automatic check_out(input logic bub, wr, input logic [3:0] num,
			input logic [31:0] data, psr, input logic up);
		check("out_bubble", bub, out_bubble);
		check("write_reg", wr, write_reg);
		if (wr) begin
			check("write_num", num, write_num);
			check("write_data", data, write_data);
		end
		if (!bub) begin
			check("out_cpsr", psr, out_cpsr);
			check("out_cpsr_up", up, out_cpsr_up);
			check("out_pc", sent_pc, out_pc);
			check("out_insn", sent_insn, out_insn);
			check("out_op0", sent_op0, out_op0);
			check("out_op1", sent_op1, out_op1);
			check("out_op2", sent_op2, out_op2);
		end
	endtask

	initial begin
		logic [31:0] i, c, s, a0, a1, a2, p, res, psr_e, held;
		logic [3:0]  op, rd;
		logic        sb, wr, j0, cr, fo;
		logic [31:0] jp0;
		{rst, stall, flush, in_bubble, carry} = 5'b10010;
		{pc, insn, cpsr, spsr, op0, op1, op2} = '0;
		repeat (9) begin
			@(negedge clk);
			check("out_bubble", 1'b1, out_bubble);
			check("write_reg", 1'b0, write_reg);
			check("out_cpsr_up", 1'b0, out_cpsr_up);
			check("jmp", 1'b0, jmp);
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("out_bubble", 1'b1, out_bubble);
		check("jmp", 1'b0, jmp);
		report("reset");

		repeat (n_alu) begin
			op = rand_bits(4);
			sb = rand_bits(1) | (op inside {4'h8, 4'h9, 4'ha, 4'hb});
			rd = rand_bits(4);
			c = {4'(rand_bits(4)), 23'(rand_bits(23)), rand_bits(1) ? 5'b10000 : 5'b10011};
			s = rand_bits(32);
			a0 = rand_bits(32);
			a1 = rand_bits(32);
			cr = rand_bits(1);
			i = {4'he, 3'b001, op, sb, 4'(rand_bits(4)), rd, 12'(rand_bits(12))};
			alu_model(op, a0, a1, c, s, sb, cr, rd, res, psr_e, wr);
			drive(1'b0, 1'b0, i, rand_bits(32), c, s, a0, a1, 32'd0, cr);
			wait_accept(j0, jp0);
			check_out(1'b0, wr, rd, res, psr_e, sb);
		end
		report("alu");

		repeat (n_mul) begin
			sb = rand_bits(1);
			wr = rand_bits(1);
			rd = rand_bits(4);
			c = {27'(rand_bits(27)), 5'b10000};
			a0 = rand_bits(32);
			// Small multipliers give short latencies.
			a1 = rand_bits(1) ? rand_bits(32) : rand_bits(6);
			a2 = rand_bits(32);
			i = {4'he, 6'b000000, wr, sb, rd, 8'(rand_bits(8)), 4'b1001, 4'(rand_bits(4))};
			res = a1 * a2 + (wr ? a0 : 32'd0);
			psr_e = c;
			if (sb)
				psr_e[31:29] = {res[31], res == 32'd0, 1'b0};
			drive(1'b0, 1'b0, i, 32'd0, c, 32'd0, a0, a1, a2, 1'b0);
			wait_accept(j0, jp0);
			check_out(1'b0, 1'b1, rd, res, psr_e, sb);
		end
		report("multiply");

		repeat (n_psr) begin
			sb = rand_bits(1);
			rd = rand_bits(4);
			c = {27'(rand_bits(27)), rand_bits(1) ? 5'b10000 : 5'b10010};
			s = rand_bits(32);
			a0 = rand_bits(32);
			i = {4'he, 5'b00010, sb, 6'b001111, rd, 12'h000};
			drive(1'b0, 1'b0, i, 32'd0, c, s, 32'd0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check_out(1'b0, 1'b1, rd, sb ? s : c, c, 1'b0);
			i = {4'he, 5'b00010, sb, 2'b10, 4'(rand_bits(4)), 4'b1111, 12'h000};
			fo = (c[4:0] == 5'b10000) || !i[16];
			drive(1'b0, 1'b0, i, 32'd0, c, s, a0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check_out(1'b0, 1'b0, 4'd0, 32'd0, sb ? c : msr_model(c, a0, fo), 1'b1);
			check("out_spsr", sb ? msr_model(s, a0, fo) : s, out_spsr);
		end
		report("psr");

		repeat (n_br) begin
			sb = rand_bits(1);
			p = {30'(rand_bits(30)), 2'b00};
			a0 = {30'(rand_bits(30)), 2'b00};
			c = rand_bits(32);
			i = {4'he, 3'b101, sb, 24'(rand_bits(24))};
			drive(1'b0, 1'b0, i, p, c, 32'd0, a0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check("jmp", 1'b1, j0);
			check("jmp_pc", p + a0 + 32'd8, jp0);
			check_out(1'b0, sb, 4'd14, p + 32'd4, c, 1'b0);
			drive(rand_bits(1), 1'b1, i, p, c, 32'd0, a0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check("jmp", 1'b0, j0);
			check_out(1'b1, 1'b0, 4'd0, 32'd0, 32'd0, 1'b0);
			drive(1'b1, 1'b0, i, p, c, 32'd0, a0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check("jmp", 1'b0, j0);
			check_out(1'b1, 1'b0, 4'd0, 32'd0, 32'd0, 1'b0);
		end
		report("branch");

		repeat (4) begin
			// Outputs of an accepted word must hold under stall.
			i = {4'he, 3'b001, 4'hd, 1'b0, 4'h0, 4'h3, 12'h000};
			a1 = rand_bits(32);
			drive(1'b0, 1'b0, i, 32'd0, 32'd0, 32'd0, 32'd0, a1, 32'd0, 1'b0);
			@(posedge clk);
			stall <= 1'b1;
			op1 <= ~a1;
			@(negedge clk);
			check("write_data", a1, write_data);
			held = write_data;
			repeat (4) begin
				@(negedge clk);
				check("write_data", held, write_data);
				check("out_bubble", 1'b0, out_bubble);
			end
			@(posedge clk);
			stall <= 1'b0;
			in_bubble <= 1'b1;
			// Flush while the multiply holds out_stall.
			i = {4'he, 6'b000000, 1'b0, 1'b1, 4'h5, 8'h00, 4'b1001, 4'h0};
			drive(1'b0, 1'b0, i, 32'd0, 32'd0, 32'd0, 32'd0, rand_bits(32), 32'd3, 1'b0);
			@(negedge clk);
			check("out_stall", 1'b1, out_stall);
			@(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
			wait_accept(j0, jp0);
			check_out(1'b1, 1'b0, 4'd0, 32'd0, 32'd0, 1'b0);
			// Load/store is recognised but not executed.
			i = {4'he, 2'b01, 26'(rand_bits(26))};
			drive(1'b0, 1'b0, i, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);
			wait_accept(j0, jp0);
			check("write_reg", 1'b0, write_reg);
			check("out_cpsr_up", 1'b0, out_cpsr_up);
		end
		report("stall_flush");

		$display("total: %0d checks, %0d errors", total_checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/arm_exec_pkg.sv
design/insn_classifier.sv
design/exec_alu.sv
design/exec_multiplier.sv
design/execute_stage.sv
design/exec_unit_top.sv
+incdir+testbench
testbench/tb_exec_unit.sv
